//--- common/tetris_pkg.sv
package tetris_pkg;

	// Piece colours, one per tetromino kind
	typedef enum logic [2:0] {
		EMPTY  = 3'd0,
		BLUE   = 3'd1, // J
		GREEN  = 3'd2, // S
		CYAN   = 3'd3, // I
		RED    = 3'd4, // Z
		PURPLE = 3'd5, // T
		YELLOW = 3'd6, // O
		WHITE  = 3'd7  // L
	} tile_t;

	typedef struct packed {
		logic down;
		logic left;
		logic right;
		logic cw;
		logic ccw;
	} buttons_t;

	typedef enum logic [2:0] {
		FALLING,
		LOCKING,
		SPAWNING,
		GAME_OVER,
		RESETTING
	} game_state_t;

	// 4x4 bitmap, cell (r, c) sits at bit 15 - (4r + c), row 0 on top
	typedef logic [15:0] shape_t;

	typedef logic [4:0] row_t;
	typedef logic [3:0] col_t;
	typedef logic [6:0] timer_t;

	localparam col_t SPAWN_COL = 4'd4;
	localparam tile_t INITIAL_PIECE = PURPLE;
	localparam int LFSR_WIDTH = 8;

endpackage : tetris_pkg

//--- source/piece_lfsr.sv
`timescale 1ns/1ps

module piece_lfsr
	import tetris_pkg::*;
(
	input  logic  clk,
	input  logic  reset_n,
	input  logic  advance,
	output tile_t kind
);

	logic [LFSR_WIDTH-1:0] lfsr_state;
	logic [2:0] raw_kind;

	// Fibonacci form, taps at 7, 5, 4 and 3
	always_ff @(posedge clk) begin
		if (!reset_n)
			lfsr_state <= LFSR_WIDTH'(1);
		else if (advance)
			lfsr_state <= {lfsr_state[LFSR_WIDTH-2:0],
				lfsr_state[3] ^ lfsr_state[4] ^ lfsr_state[5] ^ lfsr_state[7]};
	end

	// Never hand out EMPTY, fall back to the upper field and then to BLUE
	always_comb begin
		if (lfsr_state[2:0] != 3'd0)
			raw_kind = lfsr_state[2:0];
		else if (lfsr_state[5:3] != 3'd0)
			raw_kind = lfsr_state[5:3];
		else
			raw_kind = 3'd1;
	end

	assign kind = tile_t'(raw_kind);

endmodule : piece_lfsr

//--- falling_piece/tetromino_table.sv
`timescale 1ns/1ps

module tetromino_table
	import tetris_pkg::*;
(
	input  tile_t  kind,
	output shape_t shape
);

	// Spawn orientation, rows listed top to bottom
	always_comb begin
		shape = '0;
		case (kind)
			BLUE: begin
				// J
				shape = {4'b0000, 4'b1000, 4'b1110, 4'b0000};
			end
			GREEN: begin
				// S
				shape = {4'b0000, 4'b0110, 4'b1100, 4'b0000};
			end
			CYAN: begin
				// I lies flat in row 2
				shape = {4'b0000, 4'b0000, 4'b1111, 4'b0000};
			end
			RED: begin
				// Z
				shape = {4'b0000, 4'b1100, 4'b0110, 4'b0000};
			end
			PURPLE: begin
				// T
				shape = {4'b0000, 4'b0100, 4'b1110, 4'b0000};
			end
			YELLOW: begin
				// O
				shape = {4'b0000, 4'b0110, 4'b0110, 4'b0000};
			end
			WHITE: begin
				// L
				shape = {4'b0000, 4'b0010, 4'b1110, 4'b0000};
			end
			default: begin
				shape = '0;
			end
		endcase
	end

endmodule : tetromino_table

//--- falling_piece/falling_buffer.sv
`timescale 1ns/1ps

module falling_buffer
	import tetris_pkg::*;
(
	input  logic       clk,
	input  logic       reset_n,
	input  tile_t      new_kind,
	input  logic       load,
	input  logic [1:0] rotate_cw_count,
	input  logic       rotate_start,
	output shape_t     shape,
	output tile_t      kind,
	output logic       spin_busy
);

	shape_t loaded_shape;
	shape_t spun_shape;
	logic [1:0] spin_count;

	tetromino_table u_table (
		.kind  (new_kind),
		.shape (loaded_shape)
	);

	// One clockwise quarter turn of the stored shape
	always_comb begin
		spun_shape = shape;
		case (kind)
			CYAN: begin
				// Row 2 and column 1 trade places, (2, 1) maps onto itself
				for (int k = 0; k < 4; k++) begin
					spun_shape[7 - k] = shape[2 + 4 * k];
					spun_shape[2 + 4 * k] = shape[7 - k];
				end
			end
			YELLOW, EMPTY: begin
				spun_shape = shape;
			end
			default: begin
				// 3x3 box at rows 1-3, cols 0-2, new (i, j) from old (2 - j, i)
				for (int i = 0; i < 3; i++) begin
					for (int j = 0; j < 3; j++) begin
						spun_shape[11 - 4 * i - j] = shape[3 + 4 * j - i];
					end
				end
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			shape <= '0;
			kind <= EMPTY;
			spin_count <= 2'd0;
		end else if (load) begin
			shape <= loaded_shape;
			kind <= new_kind;
			spin_count <= 2'd0;
		end else if (rotate_start) begin
			spin_count <= rotate_cw_count;
		end else if (spin_count != 2'd0) begin
			shape <= spun_shape;
			spin_count <= spin_count - 2'd1;
		end
	end

	assign spin_busy = (spin_count != 2'd0);

endmodule : falling_buffer

//--- source/movement_buffer.sv
`timescale 1ns/1ps

module movement_buffer
	import tetris_pkg::*;
#(
	parameter int FALL_TIME = 60
) (
	input  logic        clk,
	input  logic        reset_n,
	input  logic        frame_tick,
	input  logic        frame_parity,
	input  game_state_t state,
	input  buttons_t    buttons,
	input  logic        collision,
	output row_t        row,
	output col_t        col,
	output logic        lock_request,
	output logic        end_request,
	output logic        rotate_start,
	output logic [1:0]  rotate_cw_count
);

	localparam timer_t FALL_RELOAD = timer_t'(FALL_TIME);

	logic act;
	row_t next_row;
	col_t next_col;
	timer_t fall_timer, next_timer;
	// One-hot record of the move made on the last even tick
	buttons_t last_move, next_move;

	assign act = frame_tick && (state == FALLING);

	always_comb begin
		next_row = row;
		next_col = col;
		next_timer = fall_timer;
		next_move = last_move;
		lock_request = 1'b0;
		end_request = 1'b0;
		rotate_start = 1'b0;
		rotate_cw_count = 2'd0;

		if (act && !frame_parity) begin
			// Even tick, take at most one move
			next_timer = fall_timer - 7'd1;
			next_move = '0;
			if (fall_timer == 7'd0 || buttons.down) begin
				next_timer = FALL_RELOAD;
				next_row = row + 5'd1;
				next_move.down = 1'b1;
			end else if (buttons.left) begin
				next_col = col - 4'd1;
				next_move.left = 1'b1;
			end else if (buttons.right) begin
				next_col = col + 4'd1;
				next_move.right = 1'b1;
			end else if (buttons.cw) begin
				rotate_start = 1'b1;
				rotate_cw_count = 2'd1;
				next_move.cw = 1'b1;
			end else if (buttons.ccw) begin
				rotate_start = 1'b1;
				rotate_cw_count = 2'd3;
				next_move.ccw = 1'b1;
			end
		end else if (act) begin
			// Odd tick, back out the last move if it collided
			next_move = '0;
			if (collision) begin
				if (last_move.left) begin
					next_col = col + 4'd1;
				end else if (last_move.right) begin
					next_col = col - 4'd1;
				end else if (last_move.down) begin
					next_row = row - 5'd1;
					lock_request = 1'b1;
				end else if (last_move.cw) begin
					rotate_start = 1'b1;
					rotate_cw_count = 2'd3;
				end else if (last_move.ccw) begin
					rotate_start = 1'b1;
					rotate_cw_count = 2'd1;
				end else begin
					// Blocked right where it spawned
					end_request = 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			row <= 5'd0;
			col <= SPAWN_COL;
			fall_timer <= FALL_RELOAD;
			last_move <= '0;
		end else if (frame_tick && state == SPAWNING) begin
			row <= 5'd0;
			col <= SPAWN_COL;
		end else begin
			row <= next_row;
			col <= next_col;
			fall_timer <= next_timer;
			last_move <= next_move;
		end
	end

endmodule : movement_buffer

//--- source/game_state.sv
`timescale 1ns/1ps

module game_state
	import tetris_pkg::*;
(
	input  logic        clk,
	input  logic        reset_n,
	input  logic        frame_tick,
	input  logic        lock_request,
	input  logic        end_request,
	input  logic        any_button,
	output game_state_t state,
	output logic        frame_parity
);

	game_state_t next_state;

	always_comb begin
		next_state = state;
		case (state)
			FALLING:   if (lock_request) next_state = LOCKING;
			LOCKING:   next_state = SPAWNING;
			SPAWNING:  next_state = FALLING;
			GAME_OVER: if (any_button) next_state = RESETTING;
			RESETTING: next_state = SPAWNING;
			default:   next_state = GAME_OVER;
		endcase

		if (end_request)
			next_state = GAME_OVER;
	end

	always_ff @(posedge clk) begin
		if (!reset_n)
			frame_parity <= 1'b0;
		else if (frame_tick)
			frame_parity <= ~frame_parity;
	end

	// Transitions only on odd ticks
	always_ff @(posedge clk) begin
		if (!reset_n)
			state <= GAME_OVER;
		else if (frame_tick && frame_parity)
			state <= next_state;
	end

endmodule : game_state

//--- source/piece_engine.sv
`timescale 1ns/1ps

module piece_engine
	import tetris_pkg::*;
#(
	parameter int FALL_TIME = 60
) (
	input  logic        clk,
	input  logic        reset_n,
	input  logic        frame_tick,
	input  buttons_t    buttons,
	input  logic        collision,
	output game_state_t state,
	output logic        frame_parity,
	output row_t        row,
	output col_t        col,
	output shape_t      shape,
	output tile_t       piece_kind,
	output tile_t       next_kind,
	output logic        spin_busy
);

	tile_t lfsr_kind;
	logic lock_request;
	logic end_request;
	logic rotate_start;
	logic [1:0] rotate_cw_count;
	logic spawn_tick;

	// Odd tick in SPAWNING, the machine moves on to FALLING here
	assign spawn_tick = frame_tick && frame_parity && (state == SPAWNING);

	game_state u_game_state (
		.clk, .reset_n, .frame_tick,
		.lock_request, .end_request,
		.any_button (|buttons),
		.state, .frame_parity
	);

	piece_lfsr u_lfsr (
		.clk, .reset_n,
		.advance (frame_tick),
		.kind    (lfsr_kind)
	);

	// Preview hands its kind to the falling piece and refills from the LFSR
	always_ff @(posedge clk) begin
		if (!reset_n)
			next_kind <= INITIAL_PIECE;
		else if (spawn_tick)
			next_kind <= lfsr_kind;
	end

	falling_buffer u_falling (
		.clk, .reset_n,
		.new_kind (next_kind),
		.load     (spawn_tick),
		.rotate_cw_count, .rotate_start,
		.shape,
		.kind     (piece_kind),
		.spin_busy
	);

	movement_buffer #(
		.FALL_TIME (FALL_TIME)
	) u_movement (
		.clk, .reset_n, .frame_tick, .frame_parity, .state,
		.buttons, .collision,
		.row, .col,
		.lock_request, .end_request,
		.rotate_start, .rotate_cw_count
	);

endmodule : piece_engine

//--- tb/tb_piece_engine.sv
`timescale 1ns/1ps

module tb_piece_engine
	import tetris_pkg::*;
();

	localparam int TICK_PERIOD = 8;
	localparam int SPIN_LIMIT = 6;

	logic clk;
	logic reset_n;
	logic frame_tick;
	logic collision;
	buttons_t buttons;

	game_state_t state;
	logic frame_parity;
	row_t row;
	col_t col;
	shape_t shape;
	tile_t piece_kind;
	tile_t next_kind;
	logic spin_busy;

	int errors;
	int checks;
	int timeouts;
	int cycles;
	int cur_step;
	logic [31:0] rnd;

	// Reference model state
	logic [7:0] model_lfsr;
	logic model_parity;
	tile_t exp_piece;
	tile_t exp_next;
	shape_t model_shape;
	game_state_t prev_state;

	// One entry per frame tick
	logic [4:0] step_buttons[$];
	logic step_collision[$];
	logic step_filler[$];
	game_state_t step_state[$];
	int step_row[$];
	int step_col[$];
	int step_turns[$];

	piece_engine #(
		.FALL_TIME (3)
	) UUT (
		.clk, .reset_n, .frame_tick, .buttons, .collision,
		.state, .frame_parity, .row, .col, .shape,
		.piece_kind, .next_kind, .spin_busy
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [7:0] lfsr_next(input logic [7:0] s);
		return {s[6:0], s[3] ^ s[4] ^ s[5] ^ s[7]};
	endfunction

	function automatic tile_t kind_from_lfsr(input logic [7:0] s);
		if (s[2:0] != 3'd0)
			return tile_t'(s[2:0]);
		else if (s[5:3] != 3'd0)
			return tile_t'(s[5:3]);
		return BLUE;
	endfunction

	function automatic shape_t spawn_bitmap(input tile_t kind);
		case (kind)
			BLUE:    return 16'h08E0;
			GREEN:   return 16'h06C0;
			CYAN:    return 16'h00F0;
			RED:     return 16'h0C60;
			PURPLE:  return 16'h04E0;
			YELLOW:  return 16'h0660;
			WHITE:   return 16'h02E0;
			default: return 16'h0000;
		endcase
	endfunction

	function automatic int cell_index(input int r, input int c);
		return 15 - 4 * r - c;
	endfunction

	// Quarter turn clockwise for the given kind
	function automatic shape_t turn_cw(input shape_t s, input tile_t kind);
		shape_t t;
		t = s;
		if (kind == CYAN) begin
			// Row 2 and column 1 trade cells around (2, 1)
			for (int k = 0; k < 4; k++) begin
				t[cell_index(2, k)] = s[cell_index(3 - k, 1)];
				t[cell_index(3 - k, 1)] = s[cell_index(2, k)];
			end
		end else if (kind != YELLOW && kind != EMPTY) begin
			for (int i = 0; i < 3; i++) begin
				for (int j = 0; j < 3; j++)
					t[cell_index(1 + i, j)] = s[cell_index(3 - j, i)];
			end
		end
		return t;
	endfunction

	task automatic check_value(input string what, input logic [15:0] actual,
		input logic [15:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("FAILED at %0t ns: step %0d %s is %h, expected %h",
				$time, cur_step, what, actual, expected);
		end
	endtask

	task automatic add_step(input logic [4:0] btn, input logic coll, input logic fill,
		input game_state_t st, input int r, input int c, input int turns);
		step_buttons.push_back(btn);
		step_collision.push_back(coll);
		step_filler.push_back(fill);
		step_state.push_back(st);
		step_row.push_back(r);
		step_col.push_back(c);
		step_turns.push_back(turns);
	endtask

	task automatic build_table();
		// buttons {down left right cw ccw}, collision, filler, state, row, col, turns
		add_step(5'b00000, 0, 1, GAME_OVER, 0, 4, 0);
		add_step(5'b00000, 0, 0, GAME_OVER, 0, 4, 0);
		add_step(5'b00000, 0, 1, GAME_OVER, 0, 4, 0);
		add_step(5'b10000, 0, 0, RESETTING, 0, 4, 0);
		add_step(5'b00000, 0, 0, RESETTING, 0, 4, 0);
		add_step(5'b00000, 0, 0, SPAWNING, 0, 4, 0);
		add_step(5'b00000, 0, 0, SPAWNING, 0, 4, 0);
		// T spawns here
		add_step(5'b00000, 0, 0, FALLING, 0, 4, 0);
		// Move priority and undo
		add_step(5'b11111, 0, 0, FALLING, 1, 4, 0);
		add_step(5'b00000, 0, 0, FALLING, 1, 4, 0);
		add_step(5'b01111, 0, 0, FALLING, 1, 3, 0);
		add_step(5'b00000, 1, 0, FALLING, 1, 4, 0);
		add_step(5'b00111, 0, 0, FALLING, 1, 5, 0);
		add_step(5'b00000, 0, 0, FALLING, 1, 5, 0);
		add_step(5'b00011, 0, 0, FALLING, 1, 5, 1);
		add_step(5'b00000, 1, 0, FALLING, 1, 5, 3);
		// Timer has run out so gravity beats ccw
		add_step(5'b00001, 0, 0, FALLING, 2, 5, 0);
		add_step(5'b00000, 0, 0, FALLING, 2, 5, 0);
		add_step(5'b00001, 0, 0, FALLING, 2, 5, 3);
		add_step(5'b00000, 1, 0, FALLING, 2, 5, 1);
		// Down mid-count reloads the timer
		add_step(5'b10000, 0, 0, FALLING, 3, 5, 0);
		add_step(5'b00000, 0, 0, FALLING, 3, 5, 0);
		add_step(5'b00000, 0, 0, FALLING, 3, 5, 0);
		add_step(5'b00000, 0, 0, FALLING, 3, 5, 0);
		add_step(5'b00000, 0, 0, FALLING, 3, 5, 0);
		add_step(5'b00000, 0, 0, FALLING, 3, 5, 0);
		add_step(5'b00000, 0, 0, FALLING, 3, 5, 0);
		add_step(5'b00000, 0, 0, FALLING, 3, 5, 0);
		add_step(5'b00000, 0, 0, FALLING, 4, 5, 0);
		// Blocked drop locks the piece
		add_step(5'b00000, 1, 0, LOCKING, 3, 5, 0);
		add_step(5'b00000, 0, 0, LOCKING, 3, 5, 0);
		add_step(5'b00000, 0, 0, SPAWNING, 3, 5, 0);
		add_step(5'b00000, 0, 0, SPAWNING, 0, 4, 0);
		// O spawns here
		add_step(5'b00000, 0, 0, FALLING, 0, 4, 0);
		add_step(5'b00010, 0, 0, FALLING, 0, 4, 1);
		add_step(5'b00000, 1, 0, FALLING, 0, 4, 3);
		add_step(5'b00001, 0, 0, FALLING, 0, 4, 3);
		add_step(5'b00000, 0, 0, FALLING, 0, 4, 0);
		add_step(5'b00000, 0, 0, FALLING, 0, 4, 0);
		// Collision without a move ends the game
		add_step(5'b00000, 1, 0, GAME_OVER, 0, 4, 0);
		add_step(5'b00000, 0, 1, GAME_OVER, 0, 4, 0);
	endtask

	initial begin
		rnd = $urandom(81350);
		reset_n = 1'b0;
		frame_tick = 1'b0;
		buttons = '0;
		collision = 1'b0;
		errors = 0;
		checks = 0;
		timeouts = 0;
		cur_step = 0;
		model_lfsr = 8'd1;
		model_parity = 1'b0;
		exp_piece = EMPTY;
		exp_next = PURPLE;
		model_shape = '0;
		prev_state = GAME_OVER;
		build_table();

		repeat (5) @(negedge clk);
		reset_n = 1'b1;
		@(negedge clk);
		check_value("state", 16'(state), 16'(GAME_OVER));
		check_value("parity", 16'(frame_parity), 16'd0);
		check_value("row", 16'(row), 16'd0);
		check_value("col", 16'(col), 16'd4);
		check_value("shape", shape, 16'h0000);
		check_value("next_kind", 16'(next_kind), 16'(PURPLE));
		check_value("spin_busy", 16'(spin_busy), 16'd0);

		for (int n = 0; n < step_state.size() && timeouts == 0; n++) begin
			cur_step = n + 1;
			if (step_filler[n]) begin
				rnd = $urandom();
				buttons = rnd[4:0];
			end else begin
				buttons = step_buttons[n];
			end
			collision = step_collision[n];
			frame_tick = 1'b1;

			// Preview moves into the falling piece on the odd tick out of SPAWNING
			if (prev_state == SPAWNING && model_parity) begin
				exp_piece = exp_next;
				exp_next = kind_from_lfsr(model_lfsr);
				model_shape = spawn_bitmap(exp_piece);
			end
			model_lfsr = lfsr_next(model_lfsr);
			model_parity = ~model_parity;
			repeat (step_turns[n]) model_shape = turn_cw(model_shape, exp_piece);

			@(negedge clk);
			frame_tick = 1'b0;
			cycles = 1;
			while (spin_busy && cycles < SPIN_LIMIT) begin
				@(negedge clk);
				cycles++;
			end
			if (spin_busy) begin
				timeouts++;
				$display("Timeout: spin_busy still high %0d cycles after tick %0d",
					cycles, cur_step);
			end else begin
				// One quarter turn per clock while busy
				check_value("spin cycles", 16'(cycles - 1), 16'(step_turns[n]));
				check_value("state", 16'(state), 16'(step_state[n]));
				check_value("parity", 16'(frame_parity), 16'(model_parity));
				check_value("row", 16'(row), 16'(step_row[n]));
				check_value("col", 16'(col), 16'(step_col[n]));
				check_value("shape", shape, model_shape);
				check_value("piece_kind", 16'(piece_kind), 16'(exp_piece));
				check_value("next_kind", 16'(next_kind), 16'(exp_next));
			end
			while (cycles < TICK_PERIOD) begin
				@(negedge clk);
				cycles++;
			end
			prev_state = step_state[n];
		end

		$display("Checks: %0d  errors: %0d  timeouts: %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule : tb_piece_engine

//--- tb.f
common/tetris_pkg.sv
source/piece_lfsr.sv
falling_piece/tetromino_table.sv
falling_piece/falling_buffer.sv
source/movement_buffer.sv
source/game_state.sv
source/piece_engine.sv
tb/tb_piece_engine.sv

//--- Makefile
VERILATOR ?= verilator
TOP       = tb_piece_engine
FILELIST  = tb.f
VFLAGS    = --timing --top-module $(TOP)
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
